// File: pce_pad_pkg.sv
// Host joystick bits are active high; console nibbles are active low; ports 5 to 7 read as empty
package pce_pad_pkg;

	// Ports on the multitap
	localparam int NUM_PADS = 5;

	//////////////////////////////////////////////////////////////////////
	// Host joystick word
	//////////////////////////////////////////////////////////////////////

	typedef logic [11:0] host_joy_t;

	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_B1     = 4;
	localparam int JOY_B2     = 5;
	localparam int JOY_SELECT = 6;
	localparam int JOY_RUN    = 7;
	localparam int JOY_B3     = 8;
	localparam int JOY_B4     = 9;
	localparam int JOY_B5     = 10;
	localparam int JOY_B6     = 11;

	//////////////////////////////////////////////////////////////////////
	// Console side
	//////////////////////////////////////////////////////////////////////

	// One nibble on the data lines, active low
	typedef logic [3:0] pad_nibble_t;

	// Four nibbles of one port, nibble 0 in the low bits
	typedef logic [15:0] pad_word_t;

	typedef logic [2:0] pad_port_t;

	// Repeated levels of button I (bit 0) and II (bit 1)
	typedef logic [1:0] turbo_bits_t;

	typedef enum logic [1:0] {
		PAD_2BTN,
		PAD_TURBO,
		PAD_6BTN
	} pad_mode_t;

	// Unpopulated tap slot, nibbles F F F 0
	localparam pad_word_t EMPTY_PORT_WORD = 16'h0FFF;

endpackage

// File: pce_mouse_pkg.sv
// Mouse report follows the host strobe-toggle format; dx is negated on capture, dy is passed as is
package pce_mouse_pkg;

	// Host report, strobe in bit 24 toggles on every new sample
	typedef logic [24:0] mouse_report_t;

	localparam int MS_LEFT   = 0;
	localparam int MS_RIGHT  = 1;
	localparam int MS_DX_LSB = 8;
	localparam int MS_DY_LSB = 16;
	localparam int MS_STROBE = 24;

	typedef logic [7:0] mouse_delta_t;

	// Which motion nibble goes out next
	typedef logic [1:0] mouse_phase_t;

	// Motion nibble over button nibble
	typedef logic [7:0] mouse_byte_t;

	//////////////////////////////////////////////////////////////////////
	// Idle timeout
	//////////////////////////////////////////////////////////////////////

	localparam int MOUSE_IDLE_BITS   = 15;
	localparam int MOUSE_IDLE_CYCLES = 32767;

	typedef logic [MOUSE_IDLE_BITS-1:0] mouse_idle_t;

endpackage

// File: pad_autofire.sv
// Turbo levels only change on a rising pad_clr; buttons III to VI of each port set the repeat rate
`timescale 1ns/1ps

module pad_autofire (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     pad_clr,
	input  pce_pad_pkg::host_joy_t   joy_0,
	input  pce_pad_pkg::host_joy_t   joy_1,
	input  pce_pad_pkg::host_joy_t   joy_2,
	input  pce_pad_pkg::host_joy_t   joy_3,
	input  pce_pad_pkg::host_joy_t   joy_4,
	output pce_pad_pkg::turbo_bits_t turbo_0,
	output pce_pad_pkg::turbo_bits_t turbo_1,
	output pce_pad_pkg::turbo_bits_t turbo_2,
	output pce_pad_pkg::turbo_bits_t turbo_3,
	output pce_pad_pkg::turbo_bits_t turbo_4
);
	import pce_pad_pkg::*;

	host_joy_t   joy_arr [NUM_PADS];
	turbo_bits_t turbo_q [NUM_PADS];
	logic        clr_d;
	logic [3:0]  turbo_cnt;

	// III and IV repeat at the slow rate, V and VI at the fast one
	function automatic turbo_bits_t repeat_bits(host_joy_t joy, logic [3:0] cnt);
		turbo_bits_t bits;
		bits[0] = joy[JOY_B1] | (joy[JOY_B3] & cnt[2]) | (joy[JOY_B5] & cnt[1]);
		bits[1] = joy[JOY_B2] | (joy[JOY_B4] & cnt[2]) | (joy[JOY_B6] & cnt[1]);
		return bits;
	endfunction

	assign joy_arr = '{joy_0, joy_1, joy_2, joy_3, joy_4};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_d     <= 1'b0;
			turbo_cnt <= '0;
			turbo_q   <= '{default: '0};
		end else begin
			clr_d <= pad_clr;
			if (pad_clr && !clr_d) begin
				turbo_cnt <= turbo_cnt + 4'd1;
				// Sampled with the count from before this pulse
				for (int i = 0; i < NUM_PADS; i++) begin
					turbo_q[i] <= repeat_bits(joy_arr[i], turbo_cnt);
				end
			end
		end
	end

	assign turbo_0 = turbo_q[0];
	assign turbo_1 = turbo_q[1];
	assign turbo_2 = turbo_q[2];
	assign turbo_3 = turbo_q[3];
	assign turbo_4 = turbo_q[4];

endmodule

// File: pad_port_scan.sv
// pad_data is registered and reads 0 while clear is high; the port only steps with multitap_en set
`timescale 1ns/1ps

module pad_port_scan (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     pad_sel,
	input  logic                     pad_clr,
	input  pce_pad_pkg::pad_mode_t   pad_mode,
	input  logic                     multitap_en,
	input  logic                     mouse_en,
	input  pce_pad_pkg::host_joy_t   joy_0,
	input  pce_pad_pkg::host_joy_t   joy_1,
	input  pce_pad_pkg::host_joy_t   joy_2,
	input  pce_pad_pkg::host_joy_t   joy_3,
	input  pce_pad_pkg::host_joy_t   joy_4,
	input  pce_pad_pkg::turbo_bits_t turbo_0,
	input  pce_pad_pkg::turbo_bits_t turbo_1,
	input  pce_pad_pkg::turbo_bits_t turbo_2,
	input  pce_pad_pkg::turbo_bits_t turbo_3,
	input  pce_pad_pkg::turbo_bits_t turbo_4,
	input  pce_mouse_pkg::mouse_byte_t mouse_byte,
	output pce_pad_pkg::pad_nibble_t pad_data
);
	import pce_pad_pkg::*;
	import pce_mouse_pkg::*;

	host_joy_t   joy_arr   [NUM_PADS];
	turbo_bits_t turbo_arr [NUM_PADS];
	pad_word_t   port_word [NUM_PADS];
	pad_word_t   sel_word;
	pad_port_t   port;
	logic        bank;
	logic        clr_d;
	logic        sel_d;
	logic        sel_rise;
	logic        use_turbo;

	//////////////////////////////////////////////////////////////////////
	// Pad word encoding
	//////////////////////////////////////////////////////////////////////

	// Nibble 3 is all zero, which marks a 6-button pad on the high bank
	function automatic pad_word_t encode_pad(host_joy_t joy, turbo_bits_t turbo,
		logic turbo_on);
		turbo_bits_t btn;
		pad_word_t   word;
		btn = turbo_on ? turbo : {joy[JOY_B2], joy[JOY_B1]};
		word = ~{4'hF,
			joy[JOY_B6], joy[JOY_B5], joy[JOY_B4], joy[JOY_B3],
			joy[JOY_LEFT], joy[JOY_DOWN], joy[JOY_RIGHT], joy[JOY_UP],
			joy[JOY_RUN], joy[JOY_SELECT], btn[1], btn[0]};
		return word;
	endfunction

	assign joy_arr   = '{joy_0, joy_1, joy_2, joy_3, joy_4};
	assign turbo_arr = '{turbo_0, turbo_1, turbo_2, turbo_3, turbo_4};
	assign use_turbo = (pad_mode == PAD_TURBO);

	always_comb begin
		for (int i = 0; i < NUM_PADS; i++) begin
			port_word[i] = encode_pad(joy_arr[i], turbo_arr[i], use_turbo);
		end
		// Mouse replaces the pad on the first port
		if (mouse_en) begin
			port_word[0] = {mouse_byte, mouse_byte};
		end
	end

	always_comb begin
		if (port < NUM_PADS) begin
			sel_word = port_word[port];
		end else begin
			sel_word = EMPTY_PORT_WORD;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Port counter, bank and output latch
	//////////////////////////////////////////////////////////////////////

	assign sel_rise = pad_sel && !sel_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_d    <= 1'b0;
			sel_d    <= 1'b0;
			port     <= '0;
			bank     <= 1'b0;
			pad_data <= '0;
		end else begin
			clr_d <= pad_clr;
			sel_d <= pad_sel;
			if (pad_clr) begin
				pad_data <= '0;
				port     <= '0;
				// Each new clear flips between the two button banks
				if (pad_mode == PAD_6BTN && !clr_d) begin
					bank <= ~bank;
				end
			end else begin
				pad_data <= sel_word[{bank, pad_sel, 2'b00} +: 4];
				if (sel_rise && multitap_en) begin
					port <= port + 3'd1;
				end
			end
			// Other pad types never see the high bank
			if (pad_mode != PAD_6BTN) begin
				bank <= 1'b0;
			end
		end
	end

endmodule

// File: pce_mouse_port.sv
// Motion is handed over only when a report restarts; a long low clear forces the next pulse to restart
`timescale 1ns/1ps

module pce_mouse_port (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         pad_clr,
	input  pce_mouse_pkg::mouse_report_t ps2_mouse,
	input  pce_pad_pkg::host_joy_t       joy_0,
	output pce_mouse_pkg::mouse_byte_t   mouse_byte
);
	import pce_pad_pkg::*;
	import pce_mouse_pkg::*;

	mouse_delta_t raw_x;
	mouse_delta_t raw_y;
	mouse_delta_t rep_x;
	mouse_delta_t rep_y;
	mouse_phase_t phase;
	mouse_idle_t  idle_cnt;
	logic         clr_d;
	logic         stb_d;
	logic [3:0]   motion;
	logic [3:0]   buttons;

	//////////////////////////////////////////////////////////////////////
	// Capture, phase and idle timeout
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_d    <= 1'b0;
			stb_d    <= 1'b0;
			raw_x    <= '0;
			raw_y    <= '0;
			rep_x    <= '0;
			rep_y    <= '0;
			phase    <= '0;
			idle_cnt <= '0;
		end else begin
			clr_d <= pad_clr;
			stb_d <= ps2_mouse[MS_STROBE];

			if (pad_clr) begin
				idle_cnt <= '0;
			end else if (idle_cnt != mouse_idle_t'(MOUSE_IDLE_CYCLES)) begin
				idle_cnt <= idle_cnt + 1'b1;
			end

			// Console gave up on the report, restart on the next pulse
			if (idle_cnt == mouse_idle_t'(MOUSE_IDLE_CYCLES)) begin
				phase <= 2'd3;
			end

			if (pad_clr && !clr_d) begin
				phase <= phase + 2'd1;
				if (phase == 2'd3) begin
					rep_x <= raw_x;
					rep_y <= raw_y;
					raw_x <= '0;
					raw_y <= '0;
				end
			end

			// A fresh host sample wins over the clear above
			if (stb_d != ps2_mouse[MS_STROBE]) begin
				raw_x <= 8'd0 - ps2_mouse[MS_DX_LSB +: 8];
				raw_y <= ps2_mouse[MS_DY_LSB +: 8];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output byte
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (phase)
			2'd0:    motion = rep_x[7:4];
			2'd1:    motion = rep_x[3:0];
			2'd2:    motion = rep_y[7:4];
			default: motion = rep_y[3:0];
		endcase
	end

	// Run and select still come from the pad
	assign buttons = ~{joy_0[JOY_RUN], joy_0[JOY_SELECT],
		ps2_mouse[MS_LEFT], ps2_mouse[MS_RIGHT]};

	assign mouse_byte = {motion, buttons};

endmodule

// File: pce_input_top.sv
// Pad lines are sampled on clk_sys without a synchronizer; pad_data settles two edges after a change
`timescale 1ns/1ps

module pce_input_top (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         pad_sel,
	input  logic                         pad_clr,
	input  pce_pad_pkg::pad_mode_t       pad_mode,
	input  logic                         multitap_en,
	input  logic                         mouse_en,
	input  pce_pad_pkg::host_joy_t       joy_0,
	input  pce_pad_pkg::host_joy_t       joy_1,
	input  pce_pad_pkg::host_joy_t       joy_2,
	input  pce_pad_pkg::host_joy_t       joy_3,
	input  pce_pad_pkg::host_joy_t       joy_4,
	input  pce_mouse_pkg::mouse_report_t ps2_mouse,
	output pce_pad_pkg::pad_nibble_t     pad_data
);
	import pce_pad_pkg::*;
	import pce_mouse_pkg::*;

	turbo_bits_t turbo_0;
	turbo_bits_t turbo_1;
	turbo_bits_t turbo_2;
	turbo_bits_t turbo_3;
	turbo_bits_t turbo_4;
	mouse_byte_t mouse_byte;

	pad_autofire u_autofire (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pad_clr (pad_clr),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.joy_2   (joy_2),
		.joy_3   (joy_3),
		.joy_4   (joy_4),
		.turbo_0 (turbo_0),
		.turbo_1 (turbo_1),
		.turbo_2 (turbo_2),
		.turbo_3 (turbo_3),
		.turbo_4 (turbo_4)
	);

	pce_mouse_port u_mouse (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pad_clr    (pad_clr),
		.ps2_mouse  (ps2_mouse),
		.joy_0      (joy_0),
		.mouse_byte (mouse_byte)
	);

	pad_port_scan u_scan (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pad_sel     (pad_sel),
		.pad_clr     (pad_clr),
		.pad_mode    (pad_mode),
		.multitap_en (multitap_en),
		.mouse_en    (mouse_en),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.joy_2       (joy_2),
		.joy_3       (joy_3),
		.joy_4       (joy_4),
		.turbo_0     (turbo_0),
		.turbo_1     (turbo_1),
		.turbo_2     (turbo_2),
		.turbo_3     (turbo_3),
		.turbo_4     (turbo_4),
		.mouse_byte  (mouse_byte),
		.pad_data    (pad_data)
	);

endmodule

// File: tb_pce_input_tests.svh
// Included inside tb_pce_input; relies on its signals, compare tasks and LFSR state
`ifndef TB_PCE_INPUT_TESTS_SVH
`define TB_PCE_INPUT_TESTS_SVH

//////////////////////////////////////////////////////////////////////
// Reference models
//////////////////////////////////////////////////////////////////////

// Active-low nibble of a pad, index is {bank, select}
function automatic pad_nibble_t pad_nibble_model(host_joy_t joy, int index);
	case (index)
		0:       return ~{joy[JOY_RUN], joy[JOY_SELECT], joy[JOY_B2], joy[JOY_B1]};
		1:       return ~{joy[JOY_LEFT], joy[JOY_DOWN], joy[JOY_RIGHT], joy[JOY_UP]};
		2:       return ~{joy[JOY_B6], joy[JOY_B5], joy[JOY_B4], joy[JOY_B3]};
		default: return 4'h0;
	endcase
endfunction

// III and IV follow count bit 2, V and VI count bit 1
function automatic turbo_bits_t turbo_model(host_joy_t joy, logic [3:0] cnt);
	turbo_bits_t level;
	level[0] = joy[JOY_B1] || (joy[JOY_B3] && cnt[2]) || (joy[JOY_B5] && cnt[1]);
	level[1] = joy[JOY_B2] || (joy[JOY_B4] && cnt[2]) || (joy[JOY_B6] && cnt[1]);
	return level;
endfunction

function automatic pad_nibble_t mouse_motion_model(mouse_delta_t dx, mouse_delta_t dy,
	int phase);
	mouse_delta_t x;
	x = ~dx + 8'd1;
	case (phase)
		0:       return x[7:4];
		1:       return x[3:0];
		2:       return dy[7:4];
		default: return dy[3:0];
	endcase
endfunction

//////////////////////////////////////////////////////////////////////
// Console line driving
//////////////////////////////////////////////////////////////////////

task automatic drive_slot();
	@(posedge clk_sys);
	#DRIVE_DELAY;
endtask

// Three edges cover the counter update and the output latch
task automatic settle();
	repeat (3) @(posedge clk_sys);
	#1;
endtask

task automatic drive_lines(logic sel, logic clr);
	drive_slot();
	if (clr && !pad_clr) begin
		clear_pulses++;
	end
	pad_sel = sel;
	pad_clr = clr;
	settle();
endtask

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

task automatic reset_clear_check();
	check_nibble("pad_data (after reset)", pad_data, 4'h0);
	drive_lines(1'b0, 1'b1);
	check_nibble("pad_data (clear, sel low)", pad_data, 4'h0);
	drive_lines(1'b1, 1'b1);
	check_nibble("pad_data (clear, sel high)", pad_data, 4'h0);
	drive_lines(1'b1, 1'b0);
	check_nibble("pad_data (idle, sel high)", pad_data, 4'hF);
	drive_lines(1'b0, 1'b0);
	check_nibble("pad_data (idle, sel low)", pad_data, 4'hF);
endtask

task automatic two_button_scan();
	host_joy_t word;
	for (int n = 0; n < 20; n++) begin
		word = host_joy_t'(random_bits(12));
		drive_slot();
		joy[0]  = word;
		pad_sel = 1'b0;
		settle();
		check_nibble("pad_data (buttons)", pad_data, pad_nibble_model(word, 0));
		drive_lines(1'b1, 1'b0);
		check_nibble("pad_data (directions)", pad_data, pad_nibble_model(word, 1));
	end
endtask

task automatic multitap_walk();
	host_joy_t words [NUM_PADS];
	drive_slot();
	multitap_en = 1'b1;
	for (int scan = 0; scan < 2; scan++) begin
		for (int p = 0; p < NUM_PADS; p++) begin
			words[p] = host_joy_t'(random_bits(12));
		end
		drive_slot();
		for (int p = 0; p < NUM_PADS; p++) begin
			joy[p] = words[p];
		end
		drive_lines(1'b1, 1'b1);
		check_nibble("pad_data (tap clear)", pad_data, 4'h0);
		drive_lines(1'b1, 1'b0);
		for (int p = 0; p < NUM_PADS; p++) begin
			check_nibble("pad_data (tap directions)", pad_data, pad_nibble_model(words[p], 1));
			drive_lines(1'b0, 1'b0);
			check_nibble("pad_data (tap buttons)", pad_data, pad_nibble_model(words[p], 0));
			drive_lines(1'b1, 1'b0);
		end
		// Ports 5 and 6 hold no pad
		for (int p = 0; p < 2; p++) begin
			check_nibble("pad_data (empty port)", pad_data, 4'hF);
			drive_lines(1'b0, 1'b0);
			check_nibble("pad_data (empty port)", pad_data, 4'hF);
			drive_lines(1'b1, 1'b0);
		end
	end
	drive_lines(1'b1, 1'b1);
	drive_lines(1'b1, 1'b0);
	check_nibble("pad_data (port 0 again)", pad_data, pad_nibble_model(words[0], 1));
	drive_slot();
	multitap_en = 1'b0;
endtask

task automatic six_button_banks();
	host_joy_t word;
	logic      high_bank;
	high_bank = 1'b0;
	drive_slot();
	pad_mode = PAD_6BTN;
	for (int n = 0; n < 6; n++) begin
		word = host_joy_t'(random_bits(12));
		drive_slot();
		joy[0] = word;
		drive_lines(1'b0, 1'b1);
		high_bank = ~high_bank;
		drive_lines(1'b0, 1'b0);
		check_nibble("pad_data (bank, sel low)", pad_data,
			pad_nibble_model(word, high_bank ? 2 : 0));
		drive_lines(1'b1, 1'b0);
		check_nibble("pad_data (bank, sel high)", pad_data,
			pad_nibble_model(word, high_bank ? 3 : 1));
	end
	drive_slot();
	pad_mode = PAD_2BTN;
endtask

task automatic turbo_repeat();
	host_joy_t   word;
	turbo_bits_t expected;
	turbo_bits_t seen;
	word         = '0;
	word[JOY_B3] = 1'b1;
	word[JOY_B5] = 1'b1;
	drive_slot();
	pad_mode = PAD_TURBO;
	joy[0]   = word;
	for (int n = 0; n < 16; n++) begin
		// Count from before this pulse
		expected = turbo_model(word, 4'(clear_pulses));
		drive_lines(1'b0, 1'b1);
		drive_lines(1'b0, 1'b0);
		seen = ~pad_data[1:0];
		check_turbo("turbo_0 (seen on pad_data)", seen, expected);
	end
	drive_slot();
	pad_mode = PAD_2BTN;
	joy[0]   = '0;
endtask

task automatic mouse_report();
	mouse_delta_t dx;
	mouse_delta_t dy;
	logic [1:0]   buttons;
	host_joy_t    word;
	pad_nibble_t  button_nibble;
	dx            = mouse_delta_t'(random_bits(8));
	dy            = mouse_delta_t'(random_bits(8));
	buttons       = 2'(random_bits(2));
	word          = host_joy_t'(random_bits(12));
	button_nibble = ~{word[JOY_RUN], word[JOY_SELECT], buttons[0], buttons[1]};
	drive_slot();
	mouse_en  = 1'b1;
	joy[0]    = word;
	ps2_mouse = {~ps2_mouse[MS_STROBE], dy, dx, 6'b0, buttons[1], buttons[0]};
	// Long idle restarts the report on the next pulse
	repeat (MOUSE_IDLE_CYCLES + 16) @(posedge clk_sys);
	for (int ph = 0; ph < 4; ph++) begin
		drive_lines(1'b1, 1'b1);
		drive_lines(1'b1, 1'b0);
		check_nibble("pad_data (mouse motion)", pad_data, mouse_motion_model(dx, dy, ph));
		drive_lines(1'b0, 1'b0);
		check_nibble("pad_data (mouse buttons)", pad_data, button_nibble);
	end
	drive_slot();
	mouse_en = 1'b0;
endtask

`endif

// File: tb_pce_input.sv
// Directed tests on one DUT; stops at the first mismatch; random data from a fixed-seed LFSR
`timescale 1ns/1ps

module tb_pce_input;
	import pce_pad_pkg::*;
	import pce_mouse_pkg::*;

	localparam int          CLK_HALF     = 20;
	localparam int          RESET_CYCLES = 8;
	localparam int          DRIVE_DELAY  = 2;
	// Mouse idle hold plus a generous bound for the short tests
	localparam int          TEST_CYCLES  = MOUSE_IDLE_CYCLES + 7200;
	localparam int          CYCLE_LIMIT  = 2 * TEST_CYCLES;
	localparam logic [31:0] LFSR_SEED    = 32'h408c_8d4c;
	localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

	logic          clk_sys;
	logic          reset;
	logic          pad_sel;
	logic          pad_clr;
	logic          multitap_en;
	logic          mouse_en;
	pad_mode_t     pad_mode;
	host_joy_t     joy [NUM_PADS];
	mouse_report_t ps2_mouse;
	pad_nibble_t   pad_data;

	logic [31:0] lfsr_state;
	int          cycle_cnt    = 0;
	int          error_count  = 0;
	// Clear rises since reset, mirrors the turbo counter
	int          clear_pulses = 0;

	pce_input_top dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pad_sel     (pad_sel),
		.pad_clr     (pad_clr),
		.pad_mode    (pad_mode),
		.multitap_en (multitap_en),
		.mouse_en    (mouse_en),
		.joy_0       (joy[0]),
		.joy_1       (joy[1]),
		.joy_2       (joy[2]),
		.joy_3       (joy[3]),
		.joy_4       (joy[4]),
		.ps2_mouse   (ps2_mouse),
		.pad_data    (pad_data)
	);

	always #CLK_HALF clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			abort_run($sformatf("Timeout, the tests did not finish in %0d cycles", CYCLE_LIMIT));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random data, one LFSR step per bit
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	function automatic logic [31:0] random_bits(int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return value;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compares
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(string reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_nibble(string name, pad_nibble_t got, pad_nibble_t expected);
		if (got !== expected) begin
			error_count++;
			$display("error t=%0t %s: got %h, expected %h", $time, name, got, expected);
			abort_run("A console nibble did not match the expected value");
		end
	endtask

	task automatic check_turbo(string name, turbo_bits_t got, turbo_bits_t expected);
		if (got !== expected) begin
			error_count++;
			$display("error t=%0t %s: got %b, expected %b", $time, name, got, expected);
			abort_run("A repeated button level did not match the expected value");
		end
	endtask

	`include "tb_pce_input_tests.svh"

	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		pad_sel     = 1'b0;
		pad_clr     = 1'b0;
		pad_mode    = PAD_2BTN;
		multitap_en = 1'b0;
		mouse_en    = 1'b0;
		ps2_mouse   = '0;
		lfsr_state  = LFSR_SEED;
		for (int i = 0; i < NUM_PADS; i++) begin
			joy[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#DRIVE_DELAY;
		reset = 1'b0;

		reset_clear_check();
		two_button_scan();
		multitap_walk();
		six_button_banks();
		turbo_repeat();
		mouse_report();

		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: pce_input_top.f
+incdir+.
pce_pad_pkg.sv
pce_mouse_pkg.sv
pad_autofire.sv
pad_port_scan.sv
pce_mouse_port.sv
pce_input_top.sv
tb_pce_input.sv

// File: Bender.yml
package:
  name: pce_input

sources:
  - files:
      - pce_pad_pkg.sv
      - pce_mouse_pkg.sv
      - pad_autofire.sv
      - pad_port_scan.sv
      - pce_mouse_port.sv
      - pce_input_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pce_input.sv
